// File: ball_motion.sv
// ball motion controller, steps the ball box once per frame and bounces it off the screen edges
module ball_motion #(
    parameter int h_active = 1024,                  // visible columns
    parameter int v_active = 768                    // visible lines
) (
    input  logic                clk,                // pixel clock
    input  logic                arst_n,
    input  logic                refresh,            // one pulse per frame, in blanking
    output xga_pkg::ball_pos_t  ball                // top-left corner of ball box
);

    // furthest corner position that keeps the box on screen
    localparam xga_pkg::coord_t h_max  = xga_pkg::coord_t'(h_active - xga_pkg::ball_size);
    localparam xga_pkg::coord_t v_max  = xga_pkg::coord_t'(v_active - xga_pkg::ball_size);
    localparam xga_pkg::coord_t h_init = xga_pkg::coord_t'((h_active - xga_pkg::ball_size) / 2);
    localparam xga_pkg::coord_t v_init = xga_pkg::coord_t'((v_active - xga_pkg::ball_size) / 2);

    xga_pkg::ball_dir_e dir;                        // current direction state
    xga_pkg::ball_dir_e dir_nxt;
    xga_pkg::coord_t    h_pos;
    xga_pkg::coord_t    v_pos;
    xga_pkg::coord_t    h_nxt;
    xga_pkg::coord_t    v_nxt;
    logic               go_left;                    // current horizontal component
    logic               go_up;                      // current vertical component
    logic               left_nxt;                   // horizontal component after bounce
    logic               up_nxt;                     // vertical component after bounce

    always_comb begin
        go_left = 1'b0;
        go_up   = 1'b0;
        case (dir)
            xga_pkg::dir_dn_rt: begin
                go_left = 1'b0;
                go_up   = 1'b0;
            end
            xga_pkg::dir_dn_lt: begin
                go_left = 1'b1;
                go_up   = 1'b0;
            end
            xga_pkg::dir_up_rt: begin
                go_left = 1'b0;
                go_up   = 1'b1;
            end
            xga_pkg::dir_up_lt: begin
                go_left = 1'b1;
                go_up   = 1'b1;
            end
            default: ;
        endcase

        // flip a component only when it points into the edge it sits on
        left_nxt = go_left ? (h_pos != '0) : (h_pos == h_max);
        up_nxt   = go_up   ? (v_pos != '0) : (v_pos == v_max);

        case ({up_nxt, left_nxt})
            2'b00:   dir_nxt = xga_pkg::dir_dn_rt;
            2'b01:   dir_nxt = xga_pkg::dir_dn_lt;
            2'b10:   dir_nxt = xga_pkg::dir_up_rt;
            default: dir_nxt = xga_pkg::dir_up_lt;
        endcase

        h_nxt = left_nxt ? h_pos - 12'd1 : h_pos + 12'd1;  // step in new direction
        v_nxt = up_nxt   ? v_pos - 12'd1 : v_pos + 12'd1;
    end

    // refresh comes at blanking start so the move never tears the picture
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dir   <= xga_pkg::dir_dn_rt;
            h_pos <= h_init;                        // centred box
            v_pos <= v_init;
        end else if (refresh) begin
            dir   <= dir_nxt;
            h_pos <= h_nxt;
            v_pos <= v_nxt;
        end
    end

    assign ball.h_pos = h_pos;
    assign ball.v_pos = v_pos;

endmodule

// File: ball_renderer.sv
// pixel renderer, paints the disc over the background and registers colour and syncs to the pins
module ball_renderer (
    input  logic                clk,                // pixel clock
    input  logic                arst_n,
    input  xga_pkg::pix_pos_t   pix,                // current raster position
    input  xga_pkg::sync_t      sync,               // sync levels for this position
    input  xga_pkg::ball_pos_t  ball,               // ball box corner
    output xga_pkg::rgb_t       vga_rgb,            // colour pins
    output logic                vga_hs,
    output logic                vga_vs,
    output logic                vga_blank_n         // high on visible pixels
);

    localparam xga_pkg::coord_t box_edge = xga_pkg::coord_t'(xga_pkg::ball_size);

    logic [xga_pkg::ball_size-1:0] disc_mask [xga_pkg::ball_size];  // one row per box line

    xga_pkg::coord_t  dx;                           // column offset from box corner
    xga_pkg::coord_t  dy;                           // line offset from box corner
    logic             in_box;                       // both offsets inside 0..31
    logic             hit;                          // pixel lies on the disc
    xga_pkg::rgb_t    rgb_nxt;

    // constant mask table, elaborated from the package rule
    for (genvar r = 0; r < xga_pkg::ball_size; r++) begin : g_row
        for (genvar c = 0; c < xga_pkg::ball_size; c++) begin : g_col
            assign disc_mask[r][c] = xga_pkg::in_disc(5'(c), 5'(r));
        end
    end

    // left or above the corner wraps to a large offset and fails the box test
    assign dx     = pix.x - ball.h_pos;
    assign dy     = pix.y - ball.v_pos;
    assign in_box = (dx < box_edge) && (dy < box_edge);
    assign hit    = in_box && disc_mask[dy[4:0]][dx[4:0]];

    always_comb begin
        if (!pix.active) begin
            rgb_nxt = '0;                           // black while blanked
        end else if (hit) begin
            rgb_nxt = xga_pkg::ball_color;
        end else begin
            rgb_nxt = xga_pkg::bg_color;
        end
    end

    // single output stage keeps colour, syncs and blank aligned
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vga_rgb     <= '0;
            vga_hs      <= 1'b1;                    // syncs idle high
            vga_vs      <= 1'b1;
            vga_blank_n <= 1'b0;
        end else begin
            vga_rgb     <= rgb_nxt;
            vga_hs      <= sync.hs;
            vga_vs      <= sync.vs;
            vga_blank_n <= pix.active;
        end
    end

endmodule

// File: tb_xga_ball.sv
// directed testbench that runs the ball top level on a small frame and compares every pixel with a model
module tb_xga_ball;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int h_active     = 64;
    localparam int h_total      = 64 + 2 + 4 + 4;    // 74 columns per line
    localparam int v_active     = 48;
    localparam int v_total      = 48 + 1 + 2 + 2;    // 53 lines per frame
    localparam int frame_cycles = h_total * v_total;
    localparam int total_frames = 58;               // frames spent by all tests together
    localparam int timeout_ns   = 2 * total_frames * frame_cycles * 10;

    logic          clk = 1'b0;
    logic          arst_n;
    xga_pkg::rgb_t vga_rgb;
    logic          vga_hs;
    logic          vga_vs;
    logic          vga_blank_n;

    int   model_h;                                  // model of the ball box corner
    int   model_v;
    logic model_left;                               // model direction components
    logic model_up;
    logic prev_vs = 1'b1;
    logic seen_right = 1'b0;                        // disc seen on the last column
    logic seen_bottom = 1'b0;                       // disc seen on the last line

    xga_ball_top #(
        .h_active (64), .h_front (2), .h_sync (4), .h_back (4),
        .v_active (48), .v_front (1), .v_sync (2), .v_back (2)
    ) i_xga_ball_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .vga_rgb     (vga_rgb),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n)
    );

    always #5 clk = ~clk;                           // 10 ns pixel clock

    task automatic report_failure(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
            report_failure("value check failed");
        end
    endtask

    // radius 16 disc on doubled coordinates so the centre is 15.5
    function automatic logic disc_hit(input int c, input int r);
        return ((2 * c - 31) * (2 * c - 31) + (2 * r - 31) * (2 * r - 31)) <= 1024;
    endfunction

    function automatic logic [23:0] expected_rgb(input int x, input int y);
        int c;
        int r;
        c = x - model_h;                            // offset inside the box
        r = y - model_v;
        if (c >= 0 && c < 32 && r >= 0 && r < 32 && disc_hit(c, r)) begin
            return 24'hFF0000;                      // red disc
        end
        return 24'h0000FF;                          // blue background
    endfunction

    // one bounce step that flips a component only when it runs into its edge
    task automatic step_model();
        if (!model_left && model_h == h_active - 32) model_left = 1'b1;
        else if (model_left && model_h == 0) model_left = 1'b0;
        if (!model_up && model_v == v_active - 32) model_up = 1'b1;
        else if (model_up && model_v == 0) model_up = 1'b0;
        model_h = model_left ? model_h - 1 : model_h + 1;
        model_v = model_up ? model_v - 1 : model_v + 1;
    endtask

    // model follows reset and steps once per frame as vs goes low
    always @(negedge clk) begin
        if (!arst_n) begin
            model_h    = (h_active - 32) / 2;       // centred box, moving down and right
            model_v    = (v_active - 32) / 2;
            model_left = 1'b0;
            model_up   = 1'b0;
            prev_vs    = 1'b1;
        end else begin
            if (prev_vs && !vga_vs) step_model();
            prev_vs = vga_vs;
        end
    end

    task automatic check_idle_pins();
        check_val("vga_hs", vga_hs, 1);
        check_val("vga_vs", vga_vs, 1);
        check_val("vga_blank_n", vga_blank_n, 0);
        check_val("vga_rgb", vga_rgb, 0);
    endtask

    task automatic wait_blank_high();
        while (vga_blank_n !== 1'b1) @(negedge clk);
    endtask

    // test 1 holds reset 5 cycles and expects idle pins up to the first pixel edge
    task automatic apply_reset();
        @(posedge clk);
        #1 arst_n = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_idle_pins();
        end
        @(posedge clk);
        #1 arst_n = 1'b1;
        @(negedge clk);
        check_idle_pins();                          // release edge still shows reset values
        @(negedge clk);
        check_val("vga_blank_n first pixel", vga_blank_n, 1);
    endtask

    // tests 3 to 5 compare every active pixel of one frame with the model
    task automatic check_frame();
        for (int y = 0; y < v_active; y++) begin
            wait_blank_high();
            for (int x = 0; x < h_active; x++) begin
                check_val($sformatf("vga_blank_n at (%0d,%0d)", x, y), vga_blank_n, 1);
                check_val($sformatf("vga_rgb at (%0d,%0d)", x, y), vga_rgb, expected_rgb(x, y));
                if (x == h_active - 1 && vga_rgb === 24'hFF0000) begin
                    seen_right = 1'b1;              // disc touches the right edge on the pins
                end
                if (y == v_active - 1 && vga_rgb === 24'hFF0000) begin
                    seen_bottom = 1'b1;             // disc touches the bottom edge on the pins
                end
                @(negedge clk);
            end
            check_val("vga_blank_n after line", vga_blank_n, 0);  // exactly 64 wide
        end
        while (vga_vs !== 1'b0) begin               // no extra line before vsync
            check_val("vga_blank_n in vertical blanking", vga_blank_n, 0);
            @(negedge clk);
        end
    endtask

    // test 2 measures line and frame periods and active run lengths over one frame
    task automatic test_timing();
        int   cycles;
        int   hs_cycles;
        int   run;
        int   runs;
        logic prev_hs;
        logic prev_v;
        prev_v = 1'b0;
        while (!(prev_v === 1'b1 && vga_vs === 1'b0)) begin
            prev_v = vga_vs;
            @(negedge clk);
        end
        cycles    = 0;
        hs_cycles = -1;                             // no hs edge seen yet
        run       = 0;
        runs      = 0;
        do begin
            prev_hs = vga_hs;
            prev_v  = vga_vs;
            @(negedge clk);
            cycles++;
            if (hs_cycles >= 0) hs_cycles++;
            if (prev_hs && !vga_hs) begin
                if (hs_cycles >= 0) check_val("vga_hs period", hs_cycles, h_total);
                hs_cycles = 0;
            end
            if (vga_blank_n) begin
                run++;
            end else if (run != 0) begin
                check_val("vga_blank_n run", run, h_active);
                runs++;
                run = 0;
            end
        end while (!(prev_v && !vga_vs));
        check_val("vga_vs period", cycles, frame_cycles);
        check_val("active lines per frame", runs, v_active);
    endtask

    task automatic test_motion();
        repeat (40) check_frame();
        if (!seen_right) report_failure("ball never reached the right edge");
        if (!seen_bottom) report_failure("ball never reached the bottom edge");
    endtask

    task automatic test_mid_reset();
        repeat (10) check_frame();
        wait_blank_high();
        repeat (200) @(negedge clk);                // well inside frame 10
        apply_reset();
        check_frame();                              // frame 0 picture again
    endtask

    initial begin
        #(timeout_ns);
        report_failure("timeout, the tests did not finish in time");
    end

    initial begin
        wait (i_xga_ball_top.i_xga_ball_checker.err_count != 0);
        report_failure("an assertion in the protocol checker failed");
    end

    initial begin
        arst_n = 1'b0;
        apply_reset();
        check_frame();
        test_timing();
        test_motion();
        test_mid_reset();
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: vga_timing.sv
// raster timing generator, counts pixels and lines and decodes active area, syncs and refresh
module vga_timing #(
    parameter int h_active = 1024,                  // visible columns
    parameter int h_front  = 24,                    // columns of front porch
    parameter int h_sync   = 136,                   // columns of hs low
    parameter int h_back   = 144,                   // columns of back porch
    parameter int v_active = 768,                   // visible lines
    parameter int v_front  = 3,                     // lines of front porch
    parameter int v_sync   = 6,                     // lines of vs low
    parameter int v_back   = 29                     // lines of back porch
) (
    input  logic               clk,                 // pixel clock
    input  logic               arst_n,
    output xga_pkg::pix_pos_t  pix,                 // position and active flag
    output xga_pkg::sync_t     sync,                // sync levels, active low
    output logic               refresh              // one pulse per frame at blanking start
);

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    // boundaries as counter-width constants
    localparam xga_pkg::coord_t h_last     = xga_pkg::coord_t'(h_total - 1);
    localparam xga_pkg::coord_t v_last     = xga_pkg::coord_t'(v_total - 1);
    localparam xga_pkg::coord_t h_act_end  = xga_pkg::coord_t'(h_active);
    localparam xga_pkg::coord_t v_act_end  = xga_pkg::coord_t'(v_active);
    localparam xga_pkg::coord_t h_sync_beg = xga_pkg::coord_t'(h_active + h_front);
    localparam xga_pkg::coord_t h_sync_end = xga_pkg::coord_t'(h_active + h_front + h_sync);
    localparam xga_pkg::coord_t v_sync_beg = xga_pkg::coord_t'(v_active + v_front);
    localparam xga_pkg::coord_t v_sync_end = xga_pkg::coord_t'(v_active + v_front + v_sync);

    xga_pkg::coord_t h_count;                       // column counter
    xga_pkg::coord_t v_count;                       // line counter
    logic            h_wrap;                        // last column of a line
    logic            v_wrap;                        // last line of a frame

    assign h_wrap = (h_count == h_last);
    assign v_wrap = (v_count == v_last);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_count <= '0;
        end else if (h_wrap) begin
            h_count <= '0;                          // start next line
        end else begin
            h_count <= h_count + 12'd1;
        end
    end

    // line counter only moves at the end of a line
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v_count <= '0;
        end else if (h_wrap) begin
            if (v_wrap) begin
                v_count <= '0;                      // start next frame
            end else begin
                v_count <= v_count + 12'd1;
            end
        end
    end

    assign pix.x      = h_count;
    assign pix.y      = v_count;
    assign pix.active = (h_count < h_act_end) && (v_count < v_act_end);  // visible window

    // syncs low only inside their windows
    assign sync.hs = !((h_count >= h_sync_beg) && (h_count < h_sync_end));
    assign sync.vs = !((v_count >= v_sync_beg) && (v_count < v_sync_end));

    assign refresh = (h_count == '0) && (v_count == v_act_end);  // first blank line, column 0

endmodule

// File: xga_ball_checker.sv
// protocol checker on the vga pins, bound into the top level to watch sync, blank and colour
module xga_ball_checker #(
    parameter int h_sync = 136                      // expected hs low width in cycles
) (
    input logic           clk,
    input logic           arst_n,
    input xga_pkg::rgb_t  vga_rgb,
    input logic           vga_hs,
    input logic           vga_vs,
    input logic           vga_blank_n
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned err_count = 0;                     // assertion failures seen so far

    // hs pulse is exactly h_sync cycles wide
    a_hs_width: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(vga_hs) |-> !vga_hs [*h_sync] ##1 vga_hs)
    else begin
        $error("hs low phase is not %0d cycles wide", h_sync);
        err_count++;
    end

    a_blank_in_sync: assert property (@(posedge clk) disable iff (!arst_n)
        !(vga_blank_n && (!vga_hs || !vga_vs)))     // no visible pixel inside a sync window
    else begin
        $error("blank_n high while a sync is low");
        err_count++;
    end

    a_black_in_blank: assert property (@(posedge clk) disable iff (!arst_n)
        !vga_blank_n |-> (vga_rgb == '0))           // colour pins dark during blanking
    else begin
        $error("colour not zero during blanking");
        err_count++;
    end

endmodule

bind xga_ball_top xga_ball_checker #(.h_sync(h_sync)) i_xga_ball_checker (
    .clk         (clk),
    .arst_n      (arst_n),
    .vga_rgb     (vga_rgb),
    .vga_hs      (vga_hs),
    .vga_vs      (vga_vs),
    .vga_blank_n (vga_blank_n)
);

// File: xga_ball_top.f
xga_pkg.sv
vga_timing.sv
ball_motion.sv
ball_renderer.sv
xga_ball_top.sv
xga_ball_checker.sv
tb_xga_ball.sv

// File: xga_ball_top.sv
// top level of the bouncing ball screensaver, sets the frame geometry and wires the blocks
module xga_ball_top #(
    parameter int h_active = 1024,                  // xga visible columns
    parameter int h_front  = 24,
    parameter int h_sync   = 136,
    parameter int h_back   = 144,
    parameter int v_active = 768,                   // xga visible lines
    parameter int v_front  = 3,
    parameter int v_sync   = 6,
    parameter int v_back   = 29                     // vertical blanking must be at least one line
) (
    input  logic           clk,                     // already the pixel clock
    input  logic           arst_n,
    output xga_pkg::rgb_t  vga_rgb,
    output logic           vga_hs,
    output logic           vga_vs,
    output logic           vga_blank_n
);

    xga_pkg::pix_pos_t  pix;                        // raster position
    xga_pkg::sync_t     sync;                       // unregistered syncs
    xga_pkg::ball_pos_t ball;                       // ball box corner
    logic               refresh;                    // frame tick

    vga_timing #(
        .h_active (h_active),
        .h_front  (h_front),
        .h_sync   (h_sync),
        .h_back   (h_back),
        .v_active (v_active),
        .v_front  (v_front),
        .v_sync   (v_sync),
        .v_back   (v_back)
    ) i_vga_timing (
        .clk      (clk),
        .arst_n   (arst_n),
        .pix      (pix),
        .sync     (sync),
        .refresh  (refresh)
    );

    ball_motion #(
        .h_active (h_active),
        .v_active (v_active)
    ) i_ball_motion (
        .clk      (clk),
        .arst_n   (arst_n),
        .refresh  (refresh),
        .ball     (ball)
    );

    ball_renderer i_ball_renderer (
        .clk         (clk),
        .arst_n      (arst_n),
        .pix         (pix),
        .sync        (sync),
        .ball        (ball),
        .vga_rgb     (vga_rgb),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n)
    );

endmodule

// File: xga_pkg.sv
// shared types, ball geometry, colours and the disc-mask rule for the xga ball design
package xga_pkg;

    typedef logic [11:0] coord_t;                   // pixel column or line number, covers xga totals
    typedef logic [7:0]  color_t;                   // one colour channel
    typedef logic [4:0]  box_idx_t;                 // column or row inside the ball box

    typedef struct packed {
        color_t r;                                  // red channel
        color_t g;                                  // green channel
        color_t b;                                  // blue channel
    } rgb_t;

    typedef struct packed {
        coord_t x;                                  // current column
        coord_t y;                                  // current line
        logic   active;                             // high inside visible area
    } pix_pos_t;

    typedef struct packed {
        logic hs;                                   // horizontal sync, active low
        logic vs;                                   // vertical sync, active low
    } sync_t;

    typedef struct packed {
        coord_t h_pos;                              // left edge of ball box
        coord_t v_pos;                              // top edge of ball box
    } ball_pos_t;

    // bit 1 set = moving up, bit 0 set = moving left
    typedef enum logic [1:0] {
        dir_dn_rt = 2'b00,
        dir_dn_lt = 2'b01,
        dir_up_rt = 2'b10,
        dir_up_lt = 2'b11
    } ball_dir_e;

    localparam int ball_size = 32;                  // edge of the square ball box

    localparam rgb_t ball_color = 24'hFF0000;       // red disc
    localparam rgb_t bg_color   = 24'h0000FF;       // blue background

    // disc test on doubled coordinates so the centre sits at 15.5, 15.5
    function automatic logic in_disc(input box_idx_t c, input box_idx_t r);
        int dx;
        int dy;
        dx = 2 * int'(c) - 31;                      // doubled distance from centre column
        dy = 2 * int'(r) - 31;                      // doubled distance from centre row
        return (dx * dx + dy * dy) <= 1024;         // radius 16 doubled is 32, squared 1024
    endfunction

endpackage
